/* files.f */
+incdir+design
design/xbar_pkg.sv
design/init_port.sv
design/target_arbiter.sv
design/resp_router.sv
design/xbar_top.sv
verif/mem_target.sv
verif/xbar_tb.sv

/* verif/xbar_tb.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_tb import xbar_pkg::*; ();

  localparam int NI      = `XBAR_N_INIT;
  localparam int NT      = `XBAR_N_TARG;
  localparam int NID     = 1 << `XBAR_ID_W;
  localparam int TIMEOUT = 200;

  logic              clk;
  logic              rst_n;
  addr_t  [NT-1:0]   start_addr;
  addr_t  [NT-1:0]   end_addr;
  iaddr_t [NI-1:0]   aw;
  logic   [NI-1:0]   aw_valid;
  logic   [NI-1:0]   aw_ready;
  wbeat_t [NI-1:0]   w;
  logic   [NI-1:0]   w_valid;
  logic   [NI-1:0]   w_ready;
  iaddr_t [NI-1:0]   ar;
  logic   [NI-1:0]   ar_valid;
  logic   [NI-1:0]   ar_ready;
  ib_t    [NI-1:0]   b_out;
  logic   [NI-1:0]   b_valid;
  logic   [NI-1:0]   b_ready;
  ir_t    [NI-1:0]   r_out;
  logic   [NI-1:0]   r_valid;
  logic   [NI-1:0]   r_ready;
  taddr_t [NT-1:0]   t_aw;
  logic   [NT-1:0]   t_aw_valid;
  logic   [NT-1:0]   t_aw_ready;
  wbeat_t [NT-1:0]   t_w;
  logic   [NT-1:0]   t_w_valid;
  logic   [NT-1:0]   t_w_ready;
  taddr_t [NT-1:0]   t_ar;
  logic   [NT-1:0]   t_ar_valid;
  logic   [NT-1:0]   t_ar_ready;
  tb_t    [NT-1:0]   t_b;
  logic   [NT-1:0]   t_b_valid;
  logic   [NT-1:0]   t_b_ready;
  tr_t    [NT-1:0]   t_r;
  logic   [NT-1:0]   t_r_valid;
  logic   [NT-1:0]   t_r_ready;
  logic   [3*NT-1:0] ready_rnd;

  // IDs issued per initiator and not yet answered
  logic [NI-1:0][NID-1:0] aw_open;
  logic [NI-1:0][NID-1:0] ar_open;
  logic [31:0]            stim_state;
  logic [31:0]            bp_state;
  data_t                  wdata [NI][NT];
  string                  test_name;
  int                     checks;
  int                     errors;

  xbar_top dut_i (
    .clk          (clk),        .rst_n        (rst_n),
    .start_addr_i (start_addr), .end_addr_i   (end_addr),
    .aw_i         (aw),         .aw_valid_i   (aw_valid),   .aw_ready_o   (aw_ready),
    .w_i          (w),          .w_valid_i    (w_valid),    .w_ready_o    (w_ready),
    .ar_i         (ar),         .ar_valid_i   (ar_valid),   .ar_ready_o   (ar_ready),
    .b_o          (b_out),      .b_valid_o    (b_valid),    .b_ready_i    (b_ready),
    .r_o          (r_out),      .r_valid_o    (r_valid),    .r_ready_i    (r_ready),
    .t_aw_o       (t_aw),       .t_aw_valid_o (t_aw_valid), .t_aw_ready_i (t_aw_ready),
    .t_w_o        (t_w),        .t_w_valid_o  (t_w_valid),  .t_w_ready_i  (t_w_ready),
    .t_ar_o       (t_ar),       .t_ar_valid_o (t_ar_valid), .t_ar_ready_i (t_ar_ready),
    .t_b_i        (t_b),        .t_b_valid_i  (t_b_valid),  .t_b_ready_o  (t_b_ready),
    .t_r_i        (t_r),        .t_r_valid_i  (t_r_valid),  .t_r_ready_o  (t_r_ready)
  );

  for (genvar k = 0; k < NT; k++)
  begin : mem_g
    mem_target mem_i (
      .clk         (clk),           .rst_n       (rst_n),
      .ready_rnd_i (ready_rnd[3*k +: 3]),
      .aw_i        (t_aw[k]),       .aw_valid_i  (t_aw_valid[k]), .aw_ready_o (t_aw_ready[k]),
      .w_i         (t_w[k]),        .w_valid_i   (t_w_valid[k]),  .w_ready_o  (t_w_ready[k]),
      .b_o         (t_b[k]),        .b_valid_o   (t_b_valid[k]),  .b_ready_i  (t_b_ready[k]),
      .ar_i        (t_ar[k]),       .ar_valid_i  (t_ar_valid[k]), .ar_ready_o (t_ar_ready[k]),
      .r_o         (t_r[k]),        .r_valid_o   (t_r_valid[k]),  .r_ready_i  (t_r_ready[k])
    );
  end

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int j = 0; j < n; j++)
    begin
      stim_state = lfsr_next(stim_state);
      v[j]       = stim_state[0];
    end
  endtask

  // Target back-pressure, three ready bits per target
  always @(posedge clk)
  begin : bp_gen
    logic [3*NT-1:0] bits;
    for (int j = 0; j < 3 * NT; j++)
    begin
      bp_state = lfsr_next(bp_state);
      bits[j]  = bp_state[0];
    end
    ready_rnd <= bits;
  end

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Test failures found");
    $finish;
  endtask

  task automatic check_request(input int k, input string ch, input taddr_t req,
                               input logic [NI-1:0][NID-1:0] open);
    addr_t lo;
    addr_t hi;
    sel_t  src;
    iid_t  id;
    lo  = 32'h1000 * k;
    hi  = lo + 32'h0FFF;
    src = req.id[`XBAR_TID_W-1 -: `XBAR_SEL_W];
    id  = req.id[`XBAR_ID_W-1:0];
    checks++;
    assert (req.addr >= lo && req.addr <= hi)
    else
    begin
      errors++;
      $display("[ERROR] %s: target %0d %s address expected %h..%h, actual %h",
               test_name, k, ch, lo, hi, req.addr);
    end
    assert (open[src][id])
    else
    begin
      errors++;
      $display("[ERROR] %s: target %0d got %s ID %h that initiator %0d never issued",
               test_name, k, ch, id, src);
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      for (int k = 0; k < NT; k++)
      begin
        if (t_aw_valid[k])
          check_request(k, "AW", t_aw[k], aw_open);
        if (t_ar_valid[k])
          check_request(k, "AR", t_ar[k], ar_open);
      end
    end
  end

  task automatic do_write(input int i, input iid_t id, input addr_t addr, input data_t data,
                          output ib_t b);
    logic aw_done;
    logic w_done;
    int   n;
    aw_done = 1'b0;
    w_done  = 1'b0;
    n       = 0;
    @(negedge clk);
    aw[i]       = {id, addr};
    w[i]        = {data, {`XBAR_STRB_W{1'b1}}};
    aw_valid[i] = 1'b1;
    w_valid[i]  = 1'b1;
    while (!(aw_done && w_done))
    begin
      @(posedge clk);
      if (aw_valid[i] && aw_ready[i])
      begin
        aw_done        = 1'b1;
        aw_open[i][id] = 1'b1;
      end
      if (w_valid[i] && w_ready[i])
        w_done = 1'b1;
      @(negedge clk);
      if (aw_done)
        aw_valid[i] = 1'b0;
      if (w_done)
        w_valid[i] = 1'b0;
      n++;
      if (!(aw_done && w_done) && n > TIMEOUT)
        abort_run($sformatf("Initiator %0d: write to %h was never accepted", i, addr));
    end
    n = 0;
    @(posedge clk);
    while (!b_valid[i])
    begin
      n++;
      if (n > TIMEOUT)
        abort_run($sformatf("Initiator %0d: no write response for %h", i, addr));
      @(posedge clk);
    end
    b              = b_out[i];
    aw_open[i][id] = 1'b0;
    check_value("B id", id, b.id);
  endtask

  task automatic do_read(input int i, input iid_t id, input addr_t addr, output ir_t r);
    int n;
    n = 0;
    @(negedge clk);
    ar[i]       = {id, addr};
    ar_valid[i] = 1'b1;
    @(posedge clk);
    while (!ar_ready[i])
    begin
      n++;
      if (n > TIMEOUT)
        abort_run($sformatf("Initiator %0d: read of %h was never accepted", i, addr));
      @(posedge clk);
    end
    ar_open[i][id] = 1'b1;
    @(negedge clk);
    ar_valid[i] = 1'b0;
    n = 0;
    @(posedge clk);
    while (!r_valid[i])
    begin
      n++;
      if (n > TIMEOUT)
        abort_run($sformatf("Initiator %0d: no read data for %h", i, addr));
      @(posedge clk);
    end
    r              = r_out[i];
    ar_open[i][id] = 1'b0;
    check_value("R id", id, r.id);
  endtask

  initial
  begin
    ib_t         b;
    ib_t         b0;
    ib_t         b1;
    ir_t         r;
    logic [31:0] rnd;
    int          tgt;
    addr_t       addr;
    data_t       d0;
    data_t       d1;
    time         t0;
    time         t1;
    rst_n      = 1'b0;
    aw         = '0;
    aw_valid   = '0;
    w          = '0;
    w_valid    = '0;
    ar         = '0;
    ar_valid   = '0;
    b_ready    = '1;
    r_ready    = '1;
    aw_open    = '0;
    ar_open    = '0;
    ready_rnd  = '0;
    checks     = 0;
    errors     = 0;
    stim_state = 32'h024c070f;
    bp_state   = 32'h024c070f;
    for (int k = 0; k < NT; k++)
    begin
      start_addr[k] = `XBAR_MAP_BASE + k * `XBAR_MAP_SIZE;
      end_addr[k]   = start_addr[k] + `XBAR_MAP_SIZE - 1;
    end

    test_name = "reset";
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_value("target AW valid", '0, t_aw_valid);
    check_value("target W valid", '0, t_w_valid);
    check_value("target AR valid", '0, t_ar_valid);
    check_value("initiator B valid", '0, b_valid);
    check_value("initiator R valid", '0, r_valid);

    test_name = "write_read";
    for (int i = 0; i < NI; i++)
    begin
      for (int k = 0; k < NT; k++)
      begin
        draw_bits(32, rnd);
        wdata[i][k] = rnd;
        do_write(i, iid_t'(i * NT + k), 32'h1000 * k + 32'h100 * i + 32'h40, rnd, b);
        check_value("B resp", RESP_OKAY, b.resp);
      end
    end
    for (int i = 0; i < NI; i++)
    begin
      for (int k = 0; k < NT; k++)
      begin
        do_read(i, iid_t'(8 + i * NT + k), 32'h1000 * k + 32'h100 * i + 32'h40, r);
        check_value("R resp", RESP_OKAY, r.resp);
        check_value("R data", wdata[i][k], r.data);
      end
    end

    test_name = "decode_error";
    for (int i = 0; i < NI; i++)
    begin
      do_write(i, iid_t'(5 + i), 32'h4000 + 32'h10 * i, 32'hDEAD_0000 + i, b);
      check_value("B resp", RESP_DECERR, b.resp);
      do_read(i, iid_t'(9 + i), 32'hFFFF_0000 + 32'h10 * i, r);
      check_value("R resp", RESP_DECERR, r.resp);
      check_value("R data", '0, r.data);
    end

    // Same address from both sides, so the later B decides the stored word
    test_name = "contention";
    for (int n = 0; n < 4; n++)
    begin
      draw_bits(2, rnd);
      tgt = rnd[1:0];
      draw_bits(10, rnd);
      addr = 32'h1000 * tgt + {rnd[9:0], 2'b00};
      draw_bits(32, rnd);
      d0 = rnd;
      draw_bits(32, rnd);
      d1 = rnd;
      fork
        begin
          do_write(0, iid_t'(n), addr, d0, b0);
          t0 = $time;
        end
        begin
          do_write(1, iid_t'(n), addr, d1, b1);
          t1 = $time;
        end
      join
      check_value("B resp initiator 0", RESP_OKAY, b0.resp);
      check_value("B resp initiator 1", RESP_OKAY, b1.resp);
      do_read(0, iid_t'(15), addr, r);
      check_value("readback", (t0 > t1) ? d0 : d1, r.data);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* verif/mem_target.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module mem_target import xbar_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [2:0] ready_rnd_i,
  input  taddr_t     aw_i,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  wbeat_t     w_i,
  input  logic       w_valid_i,
  output logic       w_ready_o,
  output tb_t        b_o,
  output logic       b_valid_o,
  input  logic       b_ready_i,
  input  taddr_t     ar_i,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  output tr_t        r_o,
  output logic       r_valid_o,
  input  logic       r_ready_i
);

  // One 4 KiB window, word addressed
  data_t  mem [1024];
  taddr_t aw_q;
  tb_t    b_q;
  tr_t    r_q;
  logic   aw_have;
  logic   b_pend;
  logic   r_pend;
  logic   live = 1'b0;

  always @(posedge clk)
  begin : state_b
    data_t word;
    live <= rst_n;
    if (!rst_n)
    begin
      aw_have <= 1'b0;
      b_pend  <= 1'b0;
      r_pend  <= 1'b0;
      b_q     <= '0;
      r_q     <= '0;
    end
    else
    begin
      if (aw_valid_i && aw_ready_o)
      begin
        aw_q    <= aw_i;
        aw_have <= 1'b1;
      end
      if (w_valid_i && w_ready_o)
      begin
        word = mem[aw_q.addr[11:2]];
        for (int n = 0; n < `XBAR_STRB_W; n++)
        begin
          if (w_i.strb[n])
            word[8*n +: 8] = w_i.data[8*n +: 8];
        end
        mem[aw_q.addr[11:2]] <= word;
        b_q    <= {aw_q.id, RESP_OKAY};
        b_pend <= 1'b1;
      end
      if (b_valid_o && b_ready_i)
      begin
        b_pend  <= 1'b0;
        aw_have <= 1'b0;
      end
      if (ar_valid_i && ar_ready_o)
      begin
        r_q    <= {ar_i.id, mem[ar_i.addr[11:2]], RESP_OKAY};
        r_pend <= 1'b1;
      end
      else if (r_valid_o && r_ready_i)
        r_pend <= 1'b0;
    end
  end

  // Outputs change only on the falling edge
  initial
  begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    r_valid_o  = 1'b0;
    b_o        = '0;
    r_o        = '0;
    forever
    begin
      @(negedge clk);
      aw_ready_o = live && !aw_have && ready_rnd_i[0];
      w_ready_o  = live && aw_have && !b_pend && ready_rnd_i[1];
      ar_ready_o = live && !r_pend && ready_rnd_i[2];
      b_valid_o  = live && b_pend;
      r_valid_o  = live && r_pend;
      b_o        = b_q;
      r_o        = r_q;
    end
  end

endmodule

/* design/xbar_top.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_top import xbar_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  addr_t [`XBAR_N_TARG-1:0]  start_addr_i,
  input  addr_t [`XBAR_N_TARG-1:0]  end_addr_i,
  input  iaddr_t [`XBAR_N_INIT-1:0] aw_i,
  input  logic [`XBAR_N_INIT-1:0]   aw_valid_i,
  output logic [`XBAR_N_INIT-1:0]   aw_ready_o,
  input  wbeat_t [`XBAR_N_INIT-1:0] w_i,
  input  logic [`XBAR_N_INIT-1:0]   w_valid_i,
  output logic [`XBAR_N_INIT-1:0]   w_ready_o,
  input  iaddr_t [`XBAR_N_INIT-1:0] ar_i,
  input  logic [`XBAR_N_INIT-1:0]   ar_valid_i,
  output logic [`XBAR_N_INIT-1:0]   ar_ready_o,
  output ib_t [`XBAR_N_INIT-1:0]    b_o,
  output logic [`XBAR_N_INIT-1:0]   b_valid_o,
  input  logic [`XBAR_N_INIT-1:0]   b_ready_i,
  output ir_t [`XBAR_N_INIT-1:0]    r_o,
  output logic [`XBAR_N_INIT-1:0]   r_valid_o,
  input  logic [`XBAR_N_INIT-1:0]   r_ready_i,
  output taddr_t [`XBAR_N_TARG-1:0] t_aw_o,
  output logic [`XBAR_N_TARG-1:0]   t_aw_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_aw_ready_i,
  output wbeat_t [`XBAR_N_TARG-1:0] t_w_o,
  output logic [`XBAR_N_TARG-1:0]   t_w_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_w_ready_i,
  output taddr_t [`XBAR_N_TARG-1:0] t_ar_o,
  output logic [`XBAR_N_TARG-1:0]   t_ar_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_ar_ready_i,
  input  tb_t [`XBAR_N_TARG-1:0]    t_b_i,
  input  logic [`XBAR_N_TARG-1:0]   t_b_valid_i,
  output logic [`XBAR_N_TARG-1:0]   t_b_ready_o,
  input  tr_t [`XBAR_N_TARG-1:0]    t_r_i,
  input  logic [`XBAR_N_TARG-1:0]   t_r_valid_i,
  output logic [`XBAR_N_TARG-1:0]   t_r_ready_o
);

  // Initiator-major on the port side, target-major on the arbiter side
  iaddr_t [`XBAR_N_INIT-1:0]                   ip_aw;
  iaddr_t [`XBAR_N_INIT-1:0]                   ip_ar;
  wbeat_t [`XBAR_N_INIT-1:0]                   ip_w;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0]   ip_aw_valid, ip_aw_ready;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0]   ip_w_valid, ip_w_ready;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0]   ip_ar_valid, ip_ar_ready;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0]   ta_aw_valid, ta_aw_ready;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0]   ta_w_valid, ta_w_ready;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0]   ta_ar_valid, ta_ar_ready;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0]   rt_b_ready, rt_r_ready;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0]   tb_ready_t, tr_ready_t;
  ib_t [`XBAR_N_INIT-1:0]                      err_b;
  ir_t [`XBAR_N_INIT-1:0]                      err_r;
  logic [`XBAR_N_INIT-1:0]                     err_b_valid, err_b_ready;
  logic [`XBAR_N_INIT-1:0]                     err_r_valid, err_r_ready;

  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : xpose_g
    for (genvar k = 0; k < `XBAR_N_TARG; k++)
    begin : targ_g
      assign ta_aw_valid[k][i] = ip_aw_valid[i][k];
      assign ip_aw_ready[i][k] = ta_aw_ready[k][i];
      assign ta_w_valid[k][i]  = ip_w_valid[i][k];
      assign ip_w_ready[i][k]  = ta_w_ready[k][i];
      assign ta_ar_valid[k][i] = ip_ar_valid[i][k];
      assign ip_ar_ready[i][k] = ta_ar_ready[k][i];
      assign tb_ready_t[k][i]  = rt_b_ready[i][k];
      assign tr_ready_t[k][i]  = rt_r_ready[i][k];
    end
  end

  // Only the router that owns the ID prefix raises a target ready
  for (genvar k = 0; k < `XBAR_N_TARG; k++)
  begin : ready_or_g
    assign t_b_ready_o[k] = |tb_ready_t[k];
    assign t_r_ready_o[k] = |tr_ready_t[k];
  end

  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : init_port_g
    init_port init_port_i (
      .clk          (clk),             .rst_n         (rst_n),
      .start_addr_i (start_addr_i),    .end_addr_i    (end_addr_i),
      .aw_i         (aw_i[i]),         .aw_valid_i    (aw_valid_i[i]),
      .aw_ready_o   (aw_ready_o[i]),   .w_i           (w_i[i]),
      .w_valid_i    (w_valid_i[i]),    .w_ready_o     (w_ready_o[i]),
      .ar_i         (ar_i[i]),         .ar_valid_i    (ar_valid_i[i]),
      .ar_ready_o   (ar_ready_o[i]),   .t_aw_o        (ip_aw[i]),
      .t_aw_valid_o (ip_aw_valid[i]),  .t_aw_ready_i  (ip_aw_ready[i]),
      .t_w_o        (ip_w[i]),         .t_w_valid_o   (ip_w_valid[i]),
      .t_w_ready_i  (ip_w_ready[i]),   .t_ar_o        (ip_ar[i]),
      .t_ar_valid_o (ip_ar_valid[i]),  .t_ar_ready_i  (ip_ar_ready[i]),
      .err_b_o      (err_b[i]),        .err_b_valid_o (err_b_valid[i]),
      .err_b_ready_i(err_b_ready[i]),  .err_r_o       (err_r[i]),
      .err_r_valid_o(err_r_valid[i]),  .err_r_ready_i (err_r_ready[i])
    );
  end

  for (genvar k = 0; k < `XBAR_N_TARG; k++)
  begin : target_arbiter_g
    target_arbiter target_arbiter_i (
      .clk          (clk),             .rst_n         (rst_n),
      .aw_i         (ip_aw),           .aw_valid_i    (ta_aw_valid[k]),
      .aw_ready_o   (ta_aw_ready[k]),  .w_i           (ip_w),
      .w_valid_i    (ta_w_valid[k]),   .w_ready_o     (ta_w_ready[k]),
      .ar_i         (ip_ar),           .ar_valid_i    (ta_ar_valid[k]),
      .ar_ready_o   (ta_ar_ready[k]),  .t_aw_o        (t_aw_o[k]),
      .t_aw_valid_o (t_aw_valid_o[k]), .t_aw_ready_i  (t_aw_ready_i[k]),
      .t_w_o        (t_w_o[k]),        .t_w_valid_o   (t_w_valid_o[k]),
      .t_w_ready_i  (t_w_ready_i[k]),  .t_ar_o        (t_ar_o[k]),
      .t_ar_valid_o (t_ar_valid_o[k]), .t_ar_ready_i  (t_ar_ready_i[k])
    );
  end

  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : resp_router_g
    resp_router #(.PORT_IDX(i)) resp_router_i (
      .clk          (clk),             .rst_n         (rst_n),
      .t_b_i        (t_b_i),           .t_b_valid_i   (t_b_valid_i),
      .t_b_ready_o  (rt_b_ready[i]),   .t_r_i         (t_r_i),
      .t_r_valid_i  (t_r_valid_i),     .t_r_ready_o   (rt_r_ready[i]),
      .err_b_i      (err_b[i]),        .err_b_valid_i (err_b_valid[i]),
      .err_b_ready_o(err_b_ready[i]),  .err_r_i       (err_r[i]),
      .err_r_valid_i(err_r_valid[i]),  .err_r_ready_o (err_r_ready[i]),
      .b_o          (b_o[i]),          .b_valid_o     (b_valid_o[i]),
      .b_ready_i    (b_ready_i[i]),    .r_o           (r_o[i]),
      .r_valid_o    (r_valid_o[i]),    .r_ready_i     (r_ready_i[i])
    );
  end

endmodule

/* design/resp_router.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module resp_router import xbar_pkg::*; #(
  parameter int PORT_IDX = 0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  tb_t [`XBAR_N_TARG-1:0]    t_b_i,
  input  logic [`XBAR_N_TARG-1:0]   t_b_valid_i,
  output logic [`XBAR_N_TARG-1:0]   t_b_ready_o,
  input  tr_t [`XBAR_N_TARG-1:0]    t_r_i,
  input  logic [`XBAR_N_TARG-1:0]   t_r_valid_i,
  output logic [`XBAR_N_TARG-1:0]   t_r_ready_o,
  input  ib_t                       err_b_i,
  input  logic                      err_b_valid_i,
  output logic                      err_b_ready_o,
  input  ir_t                       err_r_i,
  input  logic                      err_r_valid_i,
  output logic                      err_r_ready_o,
  output ib_t                       b_o,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  output ir_t                       r_o,
  output logic                      r_valid_o,
  input  logic                      r_ready_i
);

  // Targets first, the error responder is the last source
  localparam int   N_SRC  = `XBAR_N_TARG + 1;
  localparam int   SRC_W  = $clog2(N_SRC);
  localparam sel_t PREFIX = sel_t'(PORT_IDX);

  typedef logic [SRC_W-1:0] src_t;

  logic [N_SRC-1:0] b_req;
  logic [N_SRC-1:0] r_req;
  logic [N_SRC-1:0] b_grant;
  logic [N_SRC-1:0] r_grant;
  src_t             b_sel;
  src_t             r_sel;
  src_t             b_sel_q;
  src_t             r_sel_q;
  src_t             b_ptr;
  src_t             r_ptr;
  logic             b_lock;
  logic             r_lock;

  function automatic src_t rr_pick(input logic [N_SRC-1:0] req, input src_t ptr);
    src_t pick;
    int   idx;
    pick = ptr;
    for (int off = N_SRC - 1; off >= 0; off--)
    begin
      idx = (int'(ptr) + off) % N_SRC;
      if (req[idx])
        pick = src_t'(idx);
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int k = 0; k < `XBAR_N_TARG; k++)
    begin
      b_req[k] = t_b_valid_i[k] && (t_b_i[k].id[`XBAR_TID_W-1 -: `XBAR_SEL_W] == PREFIX);
      r_req[k] = t_r_valid_i[k] && (t_r_i[k].id[`XBAR_TID_W-1 -: `XBAR_SEL_W] == PREFIX);
    end
    b_req[N_SRC-1] = err_b_valid_i;
    r_req[N_SRC-1] = err_r_valid_i;
  end

  // A presented response keeps its source until it transfers
  assign b_sel = b_lock ? b_sel_q : rr_pick(b_req, b_ptr);
  assign r_sel = r_lock ? r_sel_q : rr_pick(r_req, r_ptr);

  always_comb
  begin
    b_o = err_b_i;
    r_o = err_r_i;
    if (int'(b_sel) < `XBAR_N_TARG)
      b_o = '{id: t_b_i[b_sel].id[`XBAR_ID_W-1:0], resp: t_b_i[b_sel].resp};
    if (int'(r_sel) < `XBAR_N_TARG)
      r_o = '{id: t_r_i[r_sel].id[`XBAR_ID_W-1:0], data: t_r_i[r_sel].data,
              resp: t_r_i[r_sel].resp};
    b_valid_o = b_req[b_sel];
    r_valid_o = r_req[r_sel];
    for (int s = 0; s < N_SRC; s++)
    begin
      b_grant[s] = b_ready_i && b_req[s] && (b_sel == src_t'(s));
      r_grant[s] = r_ready_i && r_req[s] && (r_sel == src_t'(s));
    end
  end

  assign t_b_ready_o   = b_grant[`XBAR_N_TARG-1:0];
  assign t_r_ready_o   = r_grant[`XBAR_N_TARG-1:0];
  assign err_b_ready_o = b_grant[N_SRC-1];
  assign err_r_ready_o = r_grant[N_SRC-1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      b_lock <= 1'b0;
      r_lock <= 1'b0;
      b_ptr  <= '0;
      r_ptr  <= '0;
    end
    else
    begin
      b_lock <= b_valid_o && !b_ready_i;
      r_lock <= r_valid_o && !r_ready_i;
      if (b_valid_o && b_ready_i)
        b_ptr <= src_t'((int'(b_sel) + 1) % N_SRC);
      if (r_valid_o && r_ready_i)
        r_ptr <= src_t'((int'(r_sel) + 1) % N_SRC);
    end
  end

  always_ff @(posedge clk)
  begin
    b_sel_q <= b_sel;
    r_sel_q <= r_sel;
  end

endmodule

/* design/target_arbiter.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module target_arbiter import xbar_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  iaddr_t [`XBAR_N_INIT-1:0]  aw_i,
  input  logic [`XBAR_N_INIT-1:0]    aw_valid_i,
  output logic [`XBAR_N_INIT-1:0]    aw_ready_o,
  input  wbeat_t [`XBAR_N_INIT-1:0]  w_i,
  input  logic [`XBAR_N_INIT-1:0]    w_valid_i,
  output logic [`XBAR_N_INIT-1:0]    w_ready_o,
  input  iaddr_t [`XBAR_N_INIT-1:0]  ar_i,
  input  logic [`XBAR_N_INIT-1:0]    ar_valid_i,
  output logic [`XBAR_N_INIT-1:0]    ar_ready_o,
  output taddr_t                     t_aw_o,
  output logic                       t_aw_valid_o,
  input  logic                       t_aw_ready_i,
  output wbeat_t                     t_w_o,
  output logic                       t_w_valid_o,
  input  logic                       t_w_ready_i,
  output taddr_t                     t_ar_o,
  output logic                       t_ar_valid_o,
  input  logic                       t_ar_ready_i
);

  wr_state_e wr_state;
  sel_t      aw_ptr;
  sel_t      ar_ptr;
  sel_t      aw_win;
  sel_t      ar_win;
  sel_t      w_owner;
  logic      aw_take;
  logic      ar_take;

  // First requester at or after the pointer
  function automatic sel_t rr_pick(input logic [`XBAR_N_INIT-1:0] req, input sel_t ptr);
    sel_t pick;
    int   idx;
    pick = ptr;
    for (int off = `XBAR_N_INIT - 1; off >= 0; off--)
    begin
      idx = (int'(ptr) + off) % `XBAR_N_INIT;
      if (req[idx])
        pick = sel_t'(idx);
    end
    return pick;
  endfunction

  function automatic sel_t rr_next(input sel_t win);
    return sel_t'((int'(win) + 1) % `XBAR_N_INIT);
  endfunction

  assign aw_win = rr_pick(aw_valid_i, aw_ptr);
  assign ar_win = rr_pick(ar_valid_i, ar_ptr);

  // A new AW waits for the previous W and for the output register to drain
  assign aw_take = |aw_valid_i && !t_aw_valid_o && (wr_state == WR_IDLE);
  assign ar_take = |ar_valid_i && !t_ar_valid_o;

  always_comb
  begin
    aw_ready_o          = '0;
    ar_ready_o          = '0;
    w_ready_o           = '0;
    aw_ready_o[aw_win]  = aw_take;
    ar_ready_o[ar_win]  = ar_take;
    w_ready_o[w_owner]  = (wr_state == WR_DATA) && t_w_ready_i;
  end

  assign t_w_o       = w_i[w_owner];
  assign t_w_valid_o = (wr_state == WR_DATA) && w_valid_i[w_owner];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      t_aw_valid_o <= 1'b0;
      t_ar_valid_o <= 1'b0;
      wr_state     <= WR_IDLE;
      w_owner      <= '0;
      aw_ptr       <= '0;
      ar_ptr       <= '0;
    end
    else
    begin
      if (aw_take)
      begin
        t_aw_valid_o <= 1'b1;
        wr_state     <= WR_DATA;
        w_owner      <= aw_win;
        aw_ptr       <= rr_next(aw_win);
      end
      else if (t_aw_ready_i)
      begin
        t_aw_valid_o <= 1'b0;
      end

      if (ar_take)
      begin
        t_ar_valid_o <= 1'b1;
        ar_ptr       <= rr_next(ar_win);
      end
      else if (t_ar_ready_i)
      begin
        t_ar_valid_o <= 1'b0;
      end

      if (t_w_valid_o && t_w_ready_i)
        wr_state <= WR_IDLE;
    end
  end

  // Initiator index goes on top of the ID
  always_ff @(posedge clk)
  begin
    if (aw_take)
      t_aw_o <= '{id: {aw_win, aw_i[aw_win].id}, addr: aw_i[aw_win].addr};
    if (ar_take)
      t_ar_o <= '{id: {ar_win, ar_i[ar_win].id}, addr: ar_i[ar_win].addr};
  end

endmodule

/* design/init_port.sv */
`timescale 1ns/1ps
`include "xbar_settings.svh"

module init_port import xbar_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  addr_t [`XBAR_N_TARG-1:0]  start_addr_i,
  input  addr_t [`XBAR_N_TARG-1:0]  end_addr_i,
  input  iaddr_t                    aw_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  wbeat_t                    w_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  input  iaddr_t                    ar_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  output iaddr_t                    t_aw_o,
  output logic [`XBAR_N_TARG-1:0]   t_aw_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_aw_ready_i,
  output wbeat_t                    t_w_o,
  output logic [`XBAR_N_TARG-1:0]   t_w_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_w_ready_i,
  output iaddr_t                    t_ar_o,
  output logic [`XBAR_N_TARG-1:0]   t_ar_valid_o,
  input  logic [`XBAR_N_TARG-1:0]   t_ar_ready_i,
  output ib_t                       err_b_o,
  output logic                      err_b_valid_o,
  input  logic                      err_b_ready_i,
  output ir_t                       err_r_o,
  output logic                      err_r_valid_o,
  input  logic                      err_r_ready_i
);

  err_state_e              err_state;
  iid_t                    err_id_q;
  logic [`XBAR_N_TARG-1:0] aw_hit;
  logic [`XBAR_N_TARG-1:0] ar_hit;
  logic [`XBAR_N_TARG-1:0] w_hit_q;
  logic                    aw_miss;
  logic                    ar_miss;
  logic                    w_pend;
  logic                    err_idle;
  logic                    err_aw_take;
  logic                    err_ar_take;

  // One-hot hit vector, end address inclusive, lowest index wins on overlap
  function automatic logic [`XBAR_N_TARG-1:0] decode(
    input addr_t                   addr,
    input addr_t [`XBAR_N_TARG-1:0] lo,
    input addr_t [`XBAR_N_TARG-1:0] hi
  );
    logic [`XBAR_N_TARG-1:0] hit;
    hit = '0;
    for (int k = `XBAR_N_TARG - 1; k >= 0; k--)
    begin
      if (addr >= lo[k] && addr <= hi[k])
      begin
        hit    = '0;
        hit[k] = 1'b1;
      end
    end
    return hit;
  endfunction

  always_comb
  begin
    aw_hit = decode(aw_i.addr, start_addr_i, end_addr_i);
    ar_hit = decode(ar_i.addr, start_addr_i, end_addr_i);
  end

  assign aw_miss  = ~|aw_hit;
  assign ar_miss  = ~|ar_hit;
  assign err_idle = (err_state == ERR_IDLE);

  // Data phase runs from the AW handshake to the W handshake
  assign w_pend      = |w_hit_q || (err_state == ERR_WDATA);
  assign err_aw_take = err_idle && aw_valid_i && aw_miss && !w_pend;
  assign err_ar_take = err_idle && ar_valid_i && ar_miss && !err_aw_take;

  assign t_aw_o       = aw_i;
  assign t_aw_valid_o = aw_hit & {`XBAR_N_TARG{aw_valid_i && !w_pend}};
  assign aw_ready_o   = !w_pend && (aw_miss ? err_idle : |(aw_hit & t_aw_ready_i));

  // W follows the target that took the last AW
  assign t_w_o       = w_i;
  assign t_w_valid_o = w_hit_q & {`XBAR_N_TARG{w_valid_i}};
  assign w_ready_o   = (err_state == ERR_WDATA) || |(w_hit_q & t_w_ready_i);

  assign t_ar_o       = ar_i;
  assign t_ar_valid_o = ar_hit & {`XBAR_N_TARG{ar_valid_i}};
  assign ar_ready_o   = ar_miss ? (err_idle && !err_aw_take) : |(ar_hit & t_ar_ready_i);

  assign err_b_o       = '{id: err_id_q, resp: RESP_DECERR};
  assign err_r_o       = '{id: err_id_q, data: '0, resp: RESP_DECERR};
  assign err_b_valid_o = (err_state == ERR_BRESP);
  assign err_r_valid_o = (err_state == ERR_RRESP);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      err_state <= ERR_IDLE;
      w_hit_q   <= '0;
    end
    else
    begin
      if (aw_valid_i && aw_ready_o)
        w_hit_q <= aw_hit;
      else if (w_valid_i && w_ready_o)
        w_hit_q <= '0;

      case (err_state)
        ERR_IDLE:
          if (err_aw_take)
            err_state <= ERR_WDATA;
          else if (err_ar_take)
            err_state <= ERR_RRESP;
        ERR_WDATA:
          if (w_valid_i)
            err_state <= ERR_BRESP;
        ERR_BRESP:
          if (err_b_ready_i)
            err_state <= ERR_IDLE;
        ERR_RRESP:
          if (err_r_ready_i)
            err_state <= ERR_IDLE;
        default:
          err_state <= ERR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (err_aw_take)
      err_id_q <= aw_i.id;
    else if (err_ar_take)
      err_id_q <= ar_i.id;
  end

endmodule

/* design/xbar_pkg.sv */
`include "xbar_settings.svh"

package xbar_pkg;

  typedef logic [`XBAR_SEL_W-1:0]  sel_t;
  typedef logic [`XBAR_ID_W-1:0]   iid_t;
  typedef logic [`XBAR_TID_W-1:0]  tid_t;
  typedef logic [`XBAR_ADDR_W-1:0] addr_t;
  typedef logic [`XBAR_DATA_W-1:0] data_t;
  typedef logic [`XBAR_STRB_W-1:0] strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    ERR_IDLE,
    ERR_WDATA,
    ERR_BRESP,
    ERR_RRESP
  } err_state_e;

  typedef enum logic {
    WR_IDLE,
    WR_DATA
  } wr_state_e;

  // Address request, shared by AW and AR
  typedef struct packed {
    iid_t  id;
    addr_t addr;
  } iaddr_t;

  // Target side carries the initiator index in the top ID bits
  typedef struct packed {
    tid_t  id;
    addr_t addr;
  } taddr_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } wbeat_t;

  typedef struct packed {
    iid_t  id;
    resp_e resp;
  } ib_t;

  typedef struct packed {
    tid_t  id;
    resp_e resp;
  } tb_t;

  typedef struct packed {
    iid_t  id;
    data_t data;
    resp_e resp;
  } ir_t;

  typedef struct packed {
    tid_t  id;
    data_t data;
    resp_e resp;
  } tr_t;

endpackage

/* design/xbar_settings.svh */
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// Port counts
`define XBAR_N_INIT 2
`define XBAR_N_TARG 4

// Channel widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32
`define XBAR_STRB_W (`XBAR_DATA_W / 8)
`define XBAR_ID_W 4
`define XBAR_SEL_W 1
`define XBAR_TID_W (`XBAR_SEL_W + `XBAR_ID_W)

// Default memory map, one window per target
`define XBAR_MAP_BASE 32'h0000_0000
`define XBAR_MAP_SIZE 32'h0000_1000

`endif
